// ==== build.f ====
hdl/zipdbg_pkg.sv
hdl/skid_buffer.sv
hdl/dbg_write_port.sv
hdl/dbg_read_port.sv
hdl/cpu_run_control.sv
hdl/zipdbg_top.sv
sim/zipdbg_checker.sv
sim/zipdbg_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the debug wrapper testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module zipdbg_tb \
	-f build.f -o zipdbg_sim || { echo "Build failed"; exit 1; }

./obj_dir/zipdbg_sim > sim.log 2>&1
cat sim.log

grep -q "TESTS FAILED" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "TESTS PASSED" sim.log && exit 0 || { echo "No pass verdict in log"; exit 1; }

// ==== sim/zipdbg_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module zipdbg_tb import zipdbg_pkg::*; ();

	localparam int PERIOD = 40;
	localparam int NUM_ROWS = 34;
	// Generous budget per table row
	localparam longint WATCHDOG_NS = longint'((NUM_ROWS * 40 + 40) * PERIOD);
	// AXI OKAY response code
	localparam logic [1:0] RESP_OKAY = 2'b00;

	typedef enum logic [1:0] {OP_WR, OP_RD, OP_HALT, OP_CNT} op_e;

	// Table row with flags {gap, stall, break, interrupt}
	typedef struct packed {
		op_e        op;
		dbg_baddr_t addr;
		dbg_word_t  data;
		dbg_strb_t  strb;
		logic [3:0] flags;
		cc_t        cc;
		dbg_word_t  exp;
	} row_t;

	logic S_AXI_ACLK;
	logic S_AXI_ARESETN;
	logic i_interrupt, i_cpu_reset;
	logic i_dbg_awvalid, i_dbg_wvalid, i_dbg_bready, i_dbg_arvalid, i_dbg_rready;
	logic o_dbg_awready, o_dbg_wready, o_dbg_bvalid, o_dbg_arready, o_dbg_rvalid;
	dbg_baddr_t i_dbg_awaddr, i_dbg_araddr;
	dbg_word_t  i_dbg_wdata, o_dbg_rdata, o_dbg_wdata;
	dbg_strb_t  i_dbg_wstrb;
	logic [1:0] o_dbg_bresp, o_dbg_rresp;
	logic o_cmd_reset, o_cmd_halt, o_cmd_step, o_cmd_clear_cache, o_dbg_we;
	reg_idx_t o_dbg_wreg, o_dbg_rreg, rreg_q;
	dbg_word_t i_dbg_rdata = '0;
	logic i_dbg_stall, i_cpu_break;
	cc_t  i_dbg_cc;

	row_t  rows [NUM_ROWS];
	string names [NUM_ROWS];
	int    n_rows = 0;
	integer seed;
	dbg_word_t regs [32];
	// Cycle counters kept by the monitor
	int n_reset = 0, n_step = 0, n_cc = 0, n_we = 0;
	int b_reset, b_step, b_cc, b_we;

	zipdbg_top dut0 (.*);

	always #(PERIOD / 2) S_AXI_ACLK = !S_AXI_ACLK;

	//////////////////////
	// CPU model
	//////////////////////

	// Sample mid-cycle where DUT outputs are settled
	always @(negedge S_AXI_ACLK)
	begin
		rreg_q <= o_dbg_rreg;
		if (o_dbg_we && !i_dbg_stall)
		begin
			regs[o_dbg_wreg] <= o_dbg_wdata;
			n_we <= n_we + 1;
		end
		if (o_cmd_reset)
			n_reset <= n_reset + 1;
		if (o_cmd_step)
			n_step <= n_step + 1;
		if (o_cmd_clear_cache)
			n_cc <= n_cc + 1;
	end

	// Read data one cycle after the index
	always @(posedge S_AXI_ACLK)
	begin
		#1;
		i_dbg_rdata = regs[rreg_q];
	end

	task automatic check_value(input string name, input dbg_word_t exp, input dbg_word_t got);
		assert (got === exp)
		else
		begin
			$display("[ERROR] %s: expected %h, actual %h", name, exp, got);
			$display("TESTS FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic next_cycle();
		@(posedge S_AXI_ACLK);
		#1;
	endtask

	task automatic add_row(input string name, input op_e op, input dbg_baddr_t addr,
		input dbg_word_t data, input dbg_strb_t strb, input logic [3:0] flags,
		input cc_t cc, input dbg_word_t exp);
		rows[n_rows] = '{op: op, addr: addr, data: data, strb: strb, flags: flags,
			cc: cc, exp: exp};
		names[n_rows] = name;
		n_rows = n_rows + 1;
	endtask

	// Random BREADY/RREADY hold-off
	function automatic int pick_gap(input logic gap);
		int g;
		g = 0;
		if (gap)
			g = ($random(seed) & 7) + 1;
		return g;
	endfunction

	task automatic axi_write(input string name, input dbg_baddr_t addr,
		input dbg_word_t data, input dbg_strb_t strb, input logic gap);
		logic aw_fire, w_fire, b_fire, aw_done, w_done, b_done;
		int   wait_n;
		wait_n = pick_gap(gap);
		i_dbg_awaddr = addr;
		i_dbg_wdata = data;
		i_dbg_wstrb = strb;
		i_dbg_awvalid = 1'b1;
		i_dbg_wvalid = 1'b1;
		i_dbg_bready = (wait_n == 0);
		aw_done = 1'b0;
		w_done = 1'b0;
		b_done = 1'b0;
		while (!aw_done || !w_done)
		begin
			aw_fire = i_dbg_awvalid && o_dbg_awready;
			w_fire = i_dbg_wvalid && o_dbg_wready;
			next_cycle();
			if (aw_fire)
			begin
				i_dbg_awvalid = 1'b0;
				aw_done = 1'b1;
			end
			if (w_fire)
			begin
				i_dbg_wvalid = 1'b0;
				w_done = 1'b1;
			end
		end
		// Hold BREADY low while the response waits
		while (!b_done)
		begin
			b_fire = o_dbg_bvalid && i_dbg_bready;
			if (b_fire)
				check_value({name, "_bresp"}, RESP_OKAY, o_dbg_bresp);
			if (o_dbg_bvalid && wait_n > 0)
				wait_n = wait_n - 1;
			next_cycle();
			b_done = b_fire;
			i_dbg_bready = (wait_n == 0);
		end
		i_dbg_bready = 1'b0;
	endtask

	task automatic axi_read(input string name, input dbg_baddr_t addr, input logic gap,
		output dbg_word_t data);
		logic ar_fire, r_fire, r_done;
		int   wait_n;
		wait_n = pick_gap(gap);
		i_dbg_araddr = addr;
		i_dbg_arvalid = 1'b1;
		i_dbg_rready = (wait_n == 0);
		r_done = 1'b0;
		while (i_dbg_arvalid)
		begin
			ar_fire = o_dbg_arready;
			next_cycle();
			if (ar_fire)
				i_dbg_arvalid = 1'b0;
		end
		while (!r_done)
		begin
			r_fire = o_dbg_rvalid && i_dbg_rready;
			data = o_dbg_rdata;
			if (r_fire)
				check_value({name, "_rresp"}, RESP_OKAY, o_dbg_rresp);
			if (o_dbg_rvalid && wait_n > 0)
				wait_n = wait_n - 1;
			next_cycle();
			r_done = r_fire;
			i_dbg_rready = (wait_n == 0);
		end
		i_dbg_rready = 1'b0;
	endtask

	task automatic fill_table();
		add_row("status_after_reset", OP_RD, 8'h00, 32'h0, 4'h0, 4'b0000, 3'd0, 32'h0000_0600);
		add_row("halted_after_reset", OP_HALT, 8'h00, 32'h0, 4'h0, 4'b0000, 3'd0, 32'h1);
		add_row("release_halt", OP_WR, 8'h00, 32'h0, 4'h2, 4'b0000, 3'd0, 32'h0);
		add_row("running", OP_HALT, 8'h00, 32'h0, 4'h0, 4'b0000, 3'd0, 32'h0);
		add_row("status_running", OP_RD, 8'h00, 32'h0, 4'h0, 4'b0000, 3'd0, 32'h0000_0200);
		add_row("reg_write_r1", OP_WR, 8'h84, 32'hDEAD_BEEF, 4'hF, 4'b1000, 3'd0, 32'h0);
		add_row("halt_on_reg_write", OP_HALT, 8'h00, 32'h0, 4'h0, 4'b0000, 3'd0, 32'h1);
		add_row("one_reg_write", OP_CNT, 8'h00, 32'h0, 4'h0, 4'b0000, 3'd0, 32'h0000_0001);
		add_row("read_r1", OP_RD, 8'h84, 32'h0, 4'h0, 4'b1000, 3'd0, 32'hDEAD_BEEF);
		add_row("reg_write_r2", OP_WR, 8'h88, 32'h1234_5678, 4'hF, 4'b0000, 3'd0, 32'h0);
		add_row("read_r2", OP_RD, 8'h88, 32'h0, 4'h0, 4'b1000, 3'd0, 32'h1234_5678);
		add_row("step_cmd", OP_WR, 8'h00, 32'h0000_0100, 4'h2, 4'b0000, 3'd0, 32'h0);
		add_row("step_pulse", OP_CNT, 8'h00, 32'h0, 4'h0, 4'b0000, 3'd0, 32'h0001_0001);
		add_row("halt_after_step", OP_HALT, 8'h00, 32'h0, 4'h0, 4'b0000, 3'd0, 32'h1);
		add_row("reset_cmd", OP_WR, 8'h00, 32'h0000_0040, 4'h1, 4'b0000, 3'd0, 32'h0);
		add_row("reset_pulse", OP_CNT, 8'h00, 32'h0, 4'h0, 4'b0000, 3'd0, 32'h0100_0000);
		add_row("halt_clear_cache", OP_WR, 8'h00, 32'h0000_0C00, 4'h2, 4'b0100, 3'd0, 32'h0);
		add_row("clear_cache_level", OP_CNT, 8'h00, 32'h0, 4'h0, 4'b0000, 3'd0, 32'h0000_0200);
		add_row("release_again", OP_WR, 8'h00, 32'h0, 4'h2, 4'b0000, 3'd0, 32'h0);
		add_row("running_again", OP_HALT, 8'h00, 32'h0, 4'h0, 4'b0000, 3'd0, 32'h0);
		add_row("status_flags", OP_RD, 8'h00, 32'h0, 4'h0, 4'b0001, 3'd5, 32'h0001_5280);
		add_row("interrupt_no_halt", OP_HALT, 8'h00, 32'h0, 4'h0, 4'b0000, 3'd0, 32'h0);
		add_row("break_halts", OP_HALT, 8'h00, 32'h0, 4'h0, 4'b0010, 3'd0, 32'h1);
		add_row("status_break_stall", OP_RD, 8'h00, 32'h0, 4'h0, 4'b0110, 3'd0, 32'h0000_8400);
		add_row("release_after_break", OP_WR, 8'h00, 32'h0, 4'h2, 4'b0000, 3'd0, 32'h0);
		add_row("running_after_break", OP_HALT, 8'h00, 32'h0, 4'h0, 4'b0000, 3'd0, 32'h0);
		add_row("stalled_reg_write", OP_WR, 8'h8C, 32'hA5A5_5A5A, 4'hF, 4'b0100, 3'd0, 32'h0);
		add_row("halt_while_stalled", OP_HALT, 8'h00, 32'h0, 4'h0, 4'b0100, 3'd0, 32'h1);
		add_row("stalled_write_lands", OP_CNT, 8'h00, 32'h0, 4'h0, 4'b0000, 3'd0, 32'h1);
		add_row("read_stalled_write", OP_RD, 8'h8C, 32'h0, 4'h0, 4'b1000, 3'd0, 32'hA5A5_5A5A);
		add_row("status_backpressure", OP_RD, 8'h00, 32'h0, 4'h0, 4'b1000, 3'd0, 32'h600);
		add_row("reg_write_backpressure", OP_WR, 8'h94, 32'h0BAD_F00D, 4'hF, 4'b1000, 3'd0,
			32'h0);
		add_row("read_backpressure", OP_RD, 8'h94, 32'h0, 4'h0, 4'b1000, 3'd0, 32'h0BAD_F00D);
		add_row("read_untouched_reg", OP_RD, 8'h98, 32'h0, 4'h0, 4'b0000, 3'd0, 32'hC0DE_0006);
	endtask

	task automatic take_baseline();
		b_reset = n_reset;
		b_step = n_step;
		b_cc = n_cc;
		b_we = n_we;
	endtask

	//////////////////////
	// Watchdog
	//////////////////////

	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before all table rows finished");
		$display("TESTS FAILED");
		$fatal(1, "timeout");
	end

	//////////////////////
	// Main sequence
	//////////////////////

	initial
	begin : main
		int        cnt;
		row_t      r;
		dbg_word_t got;
		seed = 27;
		// Fill pattern tagged with the register index
		for (int i = 0; i < 32; i++)
			regs[i] = 32'hC0DE_0000 | i;
		S_AXI_ACLK = 1'b0;
		S_AXI_ARESETN = 1'b0;
		{i_interrupt, i_cpu_reset, i_dbg_stall, i_cpu_break} = '0;
		{i_dbg_awvalid, i_dbg_wvalid, i_dbg_bready, i_dbg_arvalid, i_dbg_rready} = '0;
		i_dbg_awaddr = '0;
		i_dbg_araddr = '0;
		i_dbg_wdata = '0;
		i_dbg_wstrb = '0;
		i_dbg_cc = '0;
		fill_table();
		repeat (3) next_cycle();
		S_AXI_ARESETN = 1'b1;
		// Reset hold length counted from the release
		cnt = 0;
		while (o_cmd_reset && cnt < 64)
		begin
			cnt = cnt + 1;
			next_cycle();
		end
		check_value("reset_hold", RESET_DURATION + 1, cnt);
		check_value("idle_after_reset", 32'b00111,
			{o_dbg_bvalid, o_dbg_rvalid, o_dbg_we, o_cmd_step, o_cmd_clear_cache,
			o_dbg_awready, o_dbg_wready, o_dbg_arready});
		check_value("halt_out_of_reset", START_HALTED, o_cmd_halt);
		take_baseline();
		for (int i = 0; i < n_rows; i++)
		begin
			r = rows[i];
			{i_dbg_stall, i_cpu_break, i_interrupt} = r.flags[2:0];
			i_dbg_cc = r.cc;
			case (r.op)
			OP_WR:
				axi_write(names[i], r.addr, r.data, r.strb, r.flags[3]);
			OP_RD:
			begin
				axi_read(names[i], r.addr, r.flags[3], got);
				check_value(names[i], r.exp, got);
			end
			OP_HALT:
			begin
				repeat (2) next_cycle();
				check_value(names[i], r.exp, o_cmd_halt);
			end
			default:
			begin
				repeat (2) next_cycle();
				got = {8'(n_reset - b_reset), 8'(n_step - b_step), 8'(n_cc - b_cc),
					8'(n_we - b_we)};
				check_value(names[i], r.exp, got);
				take_baseline();
			end
			endcase
		end
		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim/zipdbg_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module zipdbg_checker (
	input wire        S_AXI_ACLK,
	input wire        S_AXI_ARESETN,
	// Response channels
	input wire        i_bvalid,
	input wire        i_bready,
	input wire        i_rvalid,
	input wire        i_rready,
	input wire [31:0] i_rdata,
	// CPU register write port
	input wire        i_we,
	input wire [4:0]  i_wreg,
	input wire [31:0] i_wdata,
	input wire        i_stall
);

	//////////////////////
	// AXI-lite responses
	//////////////////////

	// B stays up until taken
	b_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		i_bvalid && !i_bready |=> i_bvalid)
		else $error("BVALID dropped before BREADY");

	// R stays up, data frozen, until taken
	r_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		i_rvalid && !i_rready |=> i_rvalid && $stable(i_rdata))
		else $error("R response changed before RREADY");

	//////////////////////
	// Register write port
	//////////////////////

	// Stalled CPU keeps seeing the same write
	we_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		i_we && i_stall |=> i_we && $stable(i_wreg) && $stable(i_wdata))
		else $error("Register write moved while CPU stalled");

endmodule

bind zipdbg_top zipdbg_checker u_checker (
	.S_AXI_ACLK(S_AXI_ACLK),
	.S_AXI_ARESETN(S_AXI_ARESETN),
	.i_bvalid(o_dbg_bvalid),
	.i_bready(i_dbg_bready),
	.i_rvalid(o_dbg_rvalid),
	.i_rready(i_dbg_rready),
	.i_rdata(o_dbg_rdata),
	.i_we(o_dbg_we),
	.i_wreg(o_dbg_wreg),
	.i_wdata(o_dbg_wdata),
	.i_stall(i_dbg_stall)
);

`default_nettype wire

// ==== hdl/zipdbg_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module zipdbg_top import zipdbg_pkg::*; (
	input  wire        S_AXI_ACLK,
	input  wire        S_AXI_ARESETN,
	input  wire        i_interrupt,
	input  wire        i_cpu_reset,
	// AXI-lite debug bus
	input  wire        i_dbg_awvalid,
	output logic       o_dbg_awready,
	input  dbg_baddr_t i_dbg_awaddr,
	input  wire        i_dbg_wvalid,
	output logic       o_dbg_wready,
	input  dbg_word_t  i_dbg_wdata,
	input  dbg_strb_t  i_dbg_wstrb,
	output logic       o_dbg_bvalid,
	input  wire        i_dbg_bready,
	output logic [1:0] o_dbg_bresp,
	input  wire        i_dbg_arvalid,
	output logic       o_dbg_arready,
	input  dbg_baddr_t i_dbg_araddr,
	output logic       o_dbg_rvalid,
	input  wire        i_dbg_rready,
	output dbg_word_t  o_dbg_rdata,
	output logic [1:0] o_dbg_rresp,
	// CPU debug port
	output logic       o_cmd_reset,
	output logic       o_cmd_halt,
	output logic       o_cmd_step,
	output logic       o_cmd_clear_cache,
	output logic       o_dbg_we,
	output reg_idx_t   o_dbg_wreg,
	output dbg_word_t  o_dbg_wdata,
	output reg_idx_t   o_dbg_rreg,
	input  dbg_word_t  i_dbg_rdata,
	input  wire        i_dbg_stall,
	input  wire        i_cpu_break,
	input  cc_t        i_dbg_cc
);

	logic       cmd_valid;
	cmd_word_t  cmd;
	logic       reg_accept;
	reg_write_t dbg_write;
	run_state_t run;
	dbg_word_t  status;

	// Write side
	dbg_write_port u_wr (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_awvalid(i_dbg_awvalid),
		.o_awready(o_dbg_awready),
		.i_awaddr(i_dbg_awaddr),
		.i_wvalid(i_dbg_wvalid),
		.o_wready(o_dbg_wready),
		.i_wdata(i_dbg_wdata),
		.i_wstrb(i_dbg_wstrb),
		.o_bvalid(o_dbg_bvalid),
		.i_bready(i_dbg_bready),
		.o_bresp(o_dbg_bresp),
		.i_dbg_stall(i_dbg_stall),
		.o_cmd_valid(cmd_valid),
		.o_cmd(cmd),
		.o_reg_accept(reg_accept),
		.o_dbg_we(o_dbg_we),
		.o_dbg_write(dbg_write)
	);

	// Read side
	dbg_read_port u_rd (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_arvalid(i_dbg_arvalid),
		.o_arready(o_dbg_arready),
		.i_araddr(i_dbg_araddr),
		.o_rvalid(o_dbg_rvalid),
		.i_rready(i_dbg_rready),
		.o_rdata(o_dbg_rdata),
		.o_rresp(o_dbg_rresp),
		.o_dbg_rreg(o_dbg_rreg),
		.i_dbg_rdata(i_dbg_rdata),
		.i_status(status)
	);

	// Reset, halt, step, cache clear
	cpu_run_control u_run (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_cpu_reset(i_cpu_reset),
		.i_interrupt(i_interrupt),
		.i_cmd_valid(cmd_valid),
		.i_cmd(cmd),
		.i_reg_accept(reg_accept),
		.i_dbg_stall(i_dbg_stall),
		.i_cpu_break(i_cpu_break),
		.i_dbg_cc(i_dbg_cc),
		.o_run(run),
		.o_status(status)
	);

	// Struct fields out to the CPU port
	assign o_dbg_wreg = dbg_write.idx;
	assign o_dbg_wdata = dbg_write.data;
	assign o_cmd_reset = run.reset;
	assign o_cmd_halt = run.halt;
	assign o_cmd_step = run.step;
	assign o_cmd_clear_cache = run.clear_cache;

endmodule

`default_nettype wire

// ==== hdl/cpu_run_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_run_control import zipdbg_pkg::*; (
	input  wire        S_AXI_ACLK,
	input  wire        S_AXI_ARESETN,
	input  wire        i_cpu_reset,
	input  wire        i_interrupt,
	// Strobes from the write port
	input  wire        i_cmd_valid,
	input  cmd_word_t  i_cmd,
	input  wire        i_reg_accept,
	// CPU state
	input  wire        i_dbg_stall,
	input  wire        i_cpu_break,
	input  cc_t        i_dbg_cc,
	// Command levels and status
	output run_state_t o_run,
	output dbg_word_t  o_status
);

	run_ctrl_state_e state;
	rst_cnt_t        rst_cnt;
	logic            cmd_reset;
	logic            cmd_step;
	logic            cmd_clear_cache;
	logic            halt_lvl;
	logic            ctl_write;
	logic            halt_set;
	logic            halt_clr;

	//////////////////////
	// Command decode
	//////////////////////

	// Halt, step and cache bits sit in strobe lane 1
	assign ctl_write = i_cmd_valid && i_cmd.strb[1];

	// Any set wins over a release
	assign halt_set = (i_cpu_break && START_HALTED)
		|| (ctl_write && i_cmd.data[HALT_BIT] && !i_cmd.data[STEP_BIT])
		|| i_reg_accept
		|| cmd_step
		|| cmd_clear_cache
		|| (ctl_write && i_cmd.data[CLEAR_CACHE_BIT]);

	assign halt_clr = ctl_write && (!i_cmd.data[HALT_BIT] || i_cmd.data[STEP_BIT]);

	//////////////////////
	// Reset hold
	//////////////////////

	// Reloaded on any reset, counts down to zero
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_cpu_reset)
			rst_cnt <= rst_cnt_t'(RESET_DURATION);
		else if (rst_cnt != '0)
			rst_cnt <= rst_cnt - 1'b1;
	end

	// Hold, then halt or run by the command rules
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_cpu_reset)
			state <= RESET_HOLD;
		else
		begin
			case (state)
			RESET_HOLD:
				if (rst_cnt <= rst_cnt_t'(1))
					state <= START_HALTED ? HALTED : RUNNING;
			default:
				if (cmd_reset && START_HALTED)
					state <= HALTED;
				else if (halt_set)
					state <= HALTED;
				else if (halt_clr)
					state <= RUNNING;
			endcase
		end
	end

	assign halt_lvl = (state == HALTED) || ((state == RESET_HOLD) && START_HALTED);

	// Trails the hold by one cycle, or a single pulse per reset command
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_cpu_reset)
			cmd_reset <= 1'b1;
		else if (state == RESET_HOLD)
			cmd_reset <= 1'b1;
		else if (i_cpu_break && !START_HALTED)
			cmd_reset <= 1'b1;
		else
			cmd_reset <= i_cmd_valid && i_cmd.strb[0] && i_cmd.data[RESET_BIT];
	end

	//////////////////////
	// Step and cache levels
	//////////////////////

	// Step lasts until the CPU takes it
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_cpu_reset)
			cmd_step <= 1'b0;
		else if (ctl_write && i_cmd.data[STEP_BIT])
			cmd_step <= 1'b1;
		else if (!i_dbg_stall)
			cmd_step <= 1'b0;
	end

	// Cache clear drops once the CPU sits halted
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || cmd_reset)
			cmd_clear_cache <= 1'b0;
		else if (ctl_write && i_cmd.data[CLEAR_CACHE_BIT])
			cmd_clear_cache <= 1'b1;
		else if (halt_lvl && !i_dbg_stall)
			cmd_clear_cache <= 1'b0;
	end

	assign o_run = '{
		reset:       cmd_reset,
		halt:        halt_lvl,
		step:        cmd_step,
		clear_cache: cmd_clear_cache
	};

	// Status: 16 int, 15 break, 14:12 cc, 10 halt, 9 ready, 7 int, 6 reset
	assign o_status = {15'h0, i_interrupt, i_cpu_break, i_dbg_cc,
		1'b0, halt_lvl, !i_dbg_stall, 1'b0,
		i_interrupt, cmd_reset, 6'h0};

endmodule

`default_nettype wire

// ==== hdl/dbg_read_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module dbg_read_port import zipdbg_pkg::*; (
	input  wire        S_AXI_ACLK,
	input  wire        S_AXI_ARESETN,
	// AR channel
	input  wire        i_arvalid,
	output logic       o_arready,
	input  dbg_baddr_t i_araddr,
	// R channel
	output logic       o_rvalid,
	input  wire        i_rready,
	output dbg_word_t  o_rdata,
	output logic [1:0] o_rresp,
	// CPU register read port
	output reg_idx_t   o_dbg_rreg,
	input  dbg_word_t  i_dbg_rdata,
	// Status word from run control
	input  dbg_word_t  i_status
);

	dbg_addr_t ar_addr;
	logic      ar_valid;
	logic      read_ready;
	logic      is_reg;
	logic      rd_pending;

	// Address skid
	skid_buffer #(
		.DW($bits(dbg_addr_t))
	) u_ar_skid (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_valid(i_arvalid),
		.o_ready(o_arready),
		.i_data(i_araddr[DBG_ADDR_W-1:DBG_LSB]),
		.o_valid(ar_valid),
		.i_ready(read_ready),
		.o_data(ar_addr)
	);

	//////////////////////
	// Acceptance
	//////////////////////

	assign is_reg = ar_addr[SPACE_BIT];

	// One register read in flight at most, and R slot must be free
	assign read_ready = ar_valid && !rd_pending && (!o_rvalid || i_rready);

	// CPU sees the index in the acceptance cycle
	assign o_dbg_rreg = ar_addr[4:0];

	// CPU answers one cycle later
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			rd_pending <= 1'b0;
		else
			rd_pending <= read_ready && is_reg;
	end

	//////////////////////
	// R response
	//////////////////////

	// Status next cycle, register data the cycle after
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_rvalid <= 1'b0;
		else if (!o_rvalid || i_rready)
			o_rvalid <= (read_ready && !is_reg) || rd_pending;
	end

	// Held while the response waits on RREADY
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!o_rvalid || i_rready)
			o_rdata <= rd_pending ? i_dbg_rdata : i_status;
	end

	assign o_rresp = 2'b00;

endmodule

`default_nettype wire

// ==== hdl/dbg_write_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module dbg_write_port import zipdbg_pkg::*; (
	input  wire        S_AXI_ACLK,
	input  wire        S_AXI_ARESETN,
	// AW channel
	input  wire        i_awvalid,
	output logic       o_awready,
	input  dbg_baddr_t i_awaddr,
	// W channel
	input  wire        i_wvalid,
	output logic       o_wready,
	input  dbg_word_t  i_wdata,
	input  dbg_strb_t  i_wstrb,
	// B channel
	output logic       o_bvalid,
	input  wire        i_bready,
	output logic [1:0] o_bresp,
	// CPU side
	input  wire        i_dbg_stall,
	output logic       o_cmd_valid,
	output cmd_word_t  o_cmd,
	output logic       o_reg_accept,
	output logic       o_dbg_we,
	output reg_write_t o_dbg_write
);

	dbg_addr_t aw_addr;
	cmd_word_t w_word;
	logic      aw_valid;
	logic      w_valid;
	logic      write_ready;
	logic      is_cmd;
	logic      write_stall;

	//////////////////////
	// Skid buffers
	//////////////////////

	skid_buffer #(
		.DW($bits(dbg_addr_t))
	) u_aw_skid (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_valid(i_awvalid),
		.o_ready(o_awready),
		.i_data(i_awaddr[DBG_ADDR_W-1:DBG_LSB]),
		.o_valid(aw_valid),
		.i_ready(write_ready),
		.o_data(aw_addr)
	);

	// Data and strobe travel together
	skid_buffer #(
		.DW($bits(cmd_word_t))
	) u_w_skid (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_valid(i_wvalid),
		.o_ready(o_wready),
		.i_data({i_wdata, i_wstrb}),
		.o_valid(w_valid),
		.i_ready(write_ready),
		.o_data(w_word)
	);

	//////////////////////
	// Acceptance
	//////////////////////

	// Low half of the word space is the control word
	assign is_cmd = !aw_addr[SPACE_BIT];
	// Pending register write the CPU has not taken
	assign write_stall = o_dbg_we && i_dbg_stall;

	// Both halves present, B slot free, no blocked register write
	assign write_ready = aw_valid && w_valid
		&& (!o_bvalid || i_bready)
		&& (is_cmd || (w_word.strb == '0) || !write_stall);

	// One-cycle strobes to run control
	assign o_cmd_valid = write_ready && is_cmd;
	assign o_cmd = w_word;
	assign o_reg_accept = write_ready && !is_cmd && (|w_word.strb);

	// Register write lands one cycle after acceptance, frozen while stalled
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_dbg_we <= 1'b0;
		else if (!write_stall)
			o_dbg_we <= o_reg_accept;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!write_stall)
			o_dbg_write <= '{idx: aw_addr[4:0], data: w_word.data};
	end

	//////////////////////
	// B response
	//////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_bvalid <= 1'b0;
		else if (write_ready)
			o_bvalid <= 1'b1;
		else if (i_bready)
			o_bvalid <= 1'b0;
	end

	// Always OKAY
	assign o_bresp = 2'b00;

endmodule

`default_nettype wire

// ==== hdl/skid_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module skid_buffer #(
	parameter int DW = 8
) (
	input  wire          S_AXI_ACLK,
	input  wire          S_AXI_ARESETN,
	// Upstream side
	input  wire          i_valid,
	output logic         o_ready,
	input  wire [DW-1:0] i_data,
	// Downstream side
	output logic         o_valid,
	input  wire          i_ready,
	output logic [DW-1:0] o_data
);

	// Held entry
	logic          r_valid;
	logic [DW-1:0] r_data;

	// Entry parks only when upstream hands one over and downstream refuses
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			r_valid <= 1'b0;
		else if (i_valid && !r_valid && !i_ready)
			r_valid <= 1'b1;
		else if (i_ready)
			r_valid <= 1'b0;
	end

	// Capture whenever the slot is empty
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!r_valid)
			r_data <= i_data;
	end

	// Full slot blocks upstream
	assign o_ready = !r_valid;

	// Held entry first, else straight through
	assign o_valid = i_valid || r_valid;
	assign o_data = r_valid ? r_data : i_data;

endmodule

`default_nettype wire

// ==== hdl/zipdbg_pkg.sv ====
`default_nettype none

package zipdbg_pkg;

	//////////////////////
	// Debug bus geometry
	//////////////////////

	// Byte address width of the debug bus
	localparam int DBG_ADDR_W = 8;
	// Byte offset bits, dropped from every address
	localparam int DBG_LSB = 2;

	// Word address bit selecting CPU register space
	localparam int SPACE_BIT = 5;

	//////////////////////
	// Command word bits
	//////////////////////

	localparam int RESET_BIT = 6;
	localparam int STEP_BIT = 8;
	localparam int HALT_BIT = 10;
	localparam int CLEAR_CACHE_BIT = 11;

	// Initial CPU reset length in cycles
	localparam int RESET_DURATION = 10;
	// Halt out of reset and on a break
	localparam bit START_HALTED = 1'b1;

	//////////////////////
	// Shared types
	//////////////////////

	typedef logic [DBG_ADDR_W-1:0] dbg_baddr_t;
	typedef logic [DBG_ADDR_W-DBG_LSB-1:0] dbg_addr_t;
	typedef logic [31:0] dbg_word_t;
	typedef logic [3:0] dbg_strb_t;
	typedef logic [4:0] reg_idx_t;
	// Z, C, N style condition flags from the CPU
	typedef logic [2:0] cc_t;
	// Reset-hold down counter
	typedef logic [$clog2(RESET_DURATION+1)-1:0] rst_cnt_t;

	// Accepted write to the control word
	typedef struct packed {
		dbg_word_t data;
		dbg_strb_t strb;
	} cmd_word_t;

	// One write into the CPU register file
	typedef struct packed {
		reg_idx_t  idx;
		dbg_word_t data;
	} reg_write_t;

	// Command levels toward the CPU
	typedef struct packed {
		logic reset;
		logic halt;
		logic step;
		logic clear_cache;
	} run_state_t;

	// Run control FSM
	typedef enum logic [1:0] {
		RESET_HOLD = 2'd0,
		HALTED     = 2'd1,
		RUNNING    = 2'd2
	} run_ctrl_state_e;

endpackage

`default_nettype wire
